// File: Makefile
# Verilator build and run of the load/store unit testbench

SIM      := verilator
FLAGS    := --binary --timing -Wno-fatal
TOP      := tb_lsu
FILELIST := vlog.f
BUILD    := obj_dir
LOG      := sim.log
FAIL_MSG := TEST FAIL
PASS_MSG := TEST PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM), run $(TOP), search $(LOG) for the fail message"
	@echo "  clean  remove $(BUILD) and $(LOG)"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

// File: design/lsu_addr_unit.sv
/*
  word aligned bus address and trap address register
  second part address is derived from addr_last, written at the first grant
*/
module lsu_addr_unit #(
  parameter int unsigned AddrWidth = 32
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic [AddrWidth-1:0] req_addr_i,
  input  logic                 second_part_i,
  input  logic                 addr_update_i,
  output logic [AddrWidth-1:0] bus_addr_o,
  output logic [AddrWidth-1:0] addr_last_o
);

  logic [AddrWidth-1:0] addr_last_q, addr_last_d;
  logic [AddrWidth-1:0] req_word;
  logic [AddrWidth-1:0] next_word;

  // word of the request itself
  assign req_word = {req_addr_i[AddrWidth-1:2], 2'b00};

  // following word, based on the stored request address
  // so it stays valid after the requester has moved on
  assign next_word = {addr_last_q[AddrWidth-1:2] + 1'b1, 2'b00};

  assign bus_addr_o = second_part_i ? next_word : req_word;

  // full request address for a first or single part, word address otherwise
  assign addr_last_d = second_part_i ? next_word : req_addr_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_last_q <= '0;
    end else if (addr_update_i) begin
      addr_last_q <= addr_last_d;
    end
  end

  assign addr_last_o = addr_last_q;

endmodule

// File: design/lsu_ctrl_fsm.sv
/*
  access sequencer, a bus error on the first part still issues the second part
  the response is taken as valid only in IDLE, new requests wait for it
*/
module lsu_ctrl_fsm import lsu_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,

  input  logic       lsu_req_i,
  input  lsu_type_e  req_type_i,
  input  logic [1:0] req_offset_i,
  input  lsu_ctrl_t  ctrl_q_i,

  input  logic       data_gnt_i,
  input  logic       data_rvalid_i,
  input  logic       data_err_i,

  output logic       data_req_o,
  output logic       second_part_o,
  output logic       ctrl_update_o,
  output logic       rdata_update_o,
  output logic       addr_update_o,
  output logic       lsu_req_done_o,
  output logic       lsu_resp_valid_o,
  output logic       lsu_rdata_valid_o,
  output logic       load_err_o,
  output logic       store_err_o,
  output logic       busy_o
);

  ls_fsm_e ls_fsm_cs, ls_fsm_ns;

  logic split_access;
  // set after the first grant of a split access until its second grant
  logic handle_mis_q, handle_mis_d;
  // bus error seen on the first part
  logic lsu_err_q, lsu_err_d;
  logic resp_err;

  // word not on a word boundary, or half word crossing into the next word
  assign split_access =
      ((req_type_i == LSU_WORD) && (req_offset_i != 2'b00)) ||
      ((req_type_i == LSU_HALF) && (req_offset_i == 2'b11));

  //////////////////////////////////////////////////////////////////////
  // next state and strobes
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    ls_fsm_ns      = ls_fsm_cs;
    handle_mis_d   = handle_mis_q;
    lsu_err_d      = lsu_err_q;
    data_req_o     = 1'b0;
    second_part_o  = 1'b0;
    ctrl_update_o  = 1'b0;
    rdata_update_o = 1'b0;
    addr_update_o  = 1'b0;
    lsu_req_done_o = 1'b0;

    unique case (ls_fsm_cs)
      IDLE: begin
        if (lsu_req_i) begin
          data_req_o = 1'b1;
          lsu_err_d  = 1'b0;
          if (data_gnt_i) begin
            ctrl_update_o  = 1'b1;
            addr_update_o  = 1'b1;
            handle_mis_d   = split_access;
            // single access finishes its address phase right here
            lsu_req_done_o = ~split_access;
            ls_fsm_ns      = split_access ? WAIT_RVALID_MIS : IDLE;
          end else begin
            ls_fsm_ns      = split_access ? WAIT_GNT_MIS : WAIT_GNT;
          end
        end
      end

      WAIT_GNT_MIS: begin
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          ctrl_update_o = 1'b1;
          addr_update_o = 1'b1;
          handle_mis_d  = 1'b1;
          ls_fsm_ns     = WAIT_RVALID_MIS;
        end
      end

      WAIT_RVALID_MIS: begin
        // second part goes out while the first response is pending
        data_req_o     = 1'b1;
        second_part_o  = 1'b1;
        lsu_req_done_o = data_gnt_i;
        if (data_rvalid_i) begin
          lsu_err_d      = data_err_i;
          rdata_update_o = ~ctrl_q_i.we;
          // keep the first failing address on error
          addr_update_o  = data_gnt_i & ~data_err_i;
          handle_mis_d   = ~data_gnt_i;
          ls_fsm_ns      = data_gnt_i ? IDLE : WAIT_GNT;
        end else if (data_gnt_i) begin
          handle_mis_d = 1'b0;
          ls_fsm_ns    = WAIT_RVALID_MIS_GNTS_DONE;
        end
      end

      WAIT_GNT: begin
        // either a single access or the second part of a split one
        data_req_o    = 1'b1;
        second_part_o = handle_mis_q;
        if (data_gnt_i) begin
          ctrl_update_o  = 1'b1;
          addr_update_o  = ~lsu_err_q;
          handle_mis_d   = 1'b0;
          lsu_req_done_o = 1'b1;
          ls_fsm_ns      = IDLE;
        end
      end

      WAIT_RVALID_MIS_GNTS_DONE: begin
        // both parts granted, first response still outstanding
        second_part_o = 1'b1;
        if (data_rvalid_i) begin
          lsu_err_d      = data_err_i;
          addr_update_o  = ~data_err_i;
          rdata_update_o = ~ctrl_q_i.we;
          ls_fsm_ns      = IDLE;
        end
      end

      default: begin
        ls_fsm_ns = IDLE;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // state registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ls_fsm_cs    <= IDLE;
      handle_mis_q <= 1'b0;
      lsu_err_q    <= 1'b0;
    end else begin
      ls_fsm_cs    <= ls_fsm_ns;
      handle_mis_q <= handle_mis_d;
      lsu_err_q    <= lsu_err_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // response side
  //////////////////////////////////////////////////////////////////////

  // last rvalid of an access always lands in IDLE
  assign lsu_resp_valid_o = data_rvalid_i & (ls_fsm_cs == IDLE);

  // error of either part counts for the whole access
  assign resp_err = lsu_err_q | data_err_i;

  assign lsu_rdata_valid_o = lsu_resp_valid_o & ~resp_err & ~ctrl_q_i.we;
  assign load_err_o        = lsu_resp_valid_o & resp_err & ~ctrl_q_i.we;
  assign store_err_o       = lsu_resp_valid_o & resp_err & ctrl_q_i.we;

  assign busy_o = (ls_fsm_cs != IDLE);

endmodule

// File: design/lsu_load_align.sv
/*
  read data realignment and extension, result valid with the last rvalid
  the first word of a split load is held only in its upper three bytes
*/
module lsu_load_align import lsu_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        ctrl_update_i,
  input  logic        rdata_update_i,
  input  lsu_ctrl_t   ctrl_d_i,
  input  logic [31:0] data_rdata_i,
  output lsu_ctrl_t   ctrl_q_o,
  output logic [31:0] lsu_rdata_o
);

  lsu_ctrl_t   ctrl_q;
  logic [31:8] rdata_q;
  logic [31:0] rdata_w;
  logic [15:0] rdata_h;
  logic [7:0]  rdata_b;
  logic [31:0] rdata_h_ext;
  logic [31:0] rdata_b_ext;

  //////////////////////////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////////////////////////

  // access attributes, taken at each grant
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctrl_q <= '0;
    end else if (ctrl_update_i) begin
      ctrl_q <= ctrl_d_i;
    end
  end

  // upper bytes of the first word of a split load
  always_ff @(posedge clk_i) begin
    if (rdata_update_i) begin
      rdata_q <= data_rdata_i[31:8];
    end
  end

  assign ctrl_q_o = ctrl_q;

  //////////////////////////////////////////////////////////////////////
  // realignment
  //////////////////////////////////////////////////////////////////////

  // word: low bytes from the stored first word, high bytes from the bus
  always_comb begin
    unique case (ctrl_q.offset)
      2'b00:   rdata_w = data_rdata_i;
      2'b01:   rdata_w = {data_rdata_i[7:0], rdata_q[31:8]};
      2'b10:   rdata_w = {data_rdata_i[15:0], rdata_q[31:16]};
      default: rdata_w = {data_rdata_i[23:0], rdata_q[31:24]};
    endcase
  end

  // half word, offset 3 straddles both words
  always_comb begin
    unique case (ctrl_q.offset)
      2'b00:   rdata_h = data_rdata_i[15:0];
      2'b01:   rdata_h = data_rdata_i[23:8];
      2'b10:   rdata_h = data_rdata_i[31:16];
      default: rdata_h = {data_rdata_i[7:0], rdata_q[31:24]};
    endcase
  end

  // byte never splits
  assign rdata_b = data_rdata_i[{ctrl_q.offset, 3'b000} +: 8];

  //////////////////////////////////////////////////////////////////////
  // extension and result select
  //////////////////////////////////////////////////////////////////////

  assign rdata_h_ext = ctrl_q.sign_ext ? {{16{rdata_h[15]}}, rdata_h} : {16'h0000, rdata_h};
  assign rdata_b_ext = ctrl_q.sign_ext ? {{24{rdata_b[7]}}, rdata_b} : {24'h00_0000, rdata_b};

  always_comb begin
    unique case (ctrl_q.data_type)
      LSU_WORD: lsu_rdata_o = rdata_w;
      LSU_HALF: lsu_rdata_o = rdata_h_ext;
      // both upper codes are byte loads
      default:  lsu_rdata_o = rdata_b_ext;
    endcase
  end

endmodule

// File: design/lsu_pkg.sv
/*
  shared types for the load/store unit, bus data width fixed at 32 bits
  type codes 2'b10 and 2'b11 both decode as a byte access
*/
package lsu_pkg;

  //////////////////////////////////////////////////////////////////////
  // access encodings
  //////////////////////////////////////////////////////////////////////

  // access size as issued by the execute stage
  typedef enum logic [1:0] {
    LSU_WORD = 2'b00,
    LSU_HALF = 2'b01,
    LSU_BYTE = 2'b10
  } lsu_type_e;

  // controller states
  // the _MIS states belong to the first part of a split access
  typedef enum logic [2:0] {
    IDLE,
    WAIT_GNT_MIS,
    WAIT_RVALID_MIS,
    WAIT_GNT,
    WAIT_RVALID_MIS_GNTS_DONE
  } ls_fsm_e;

  //////////////////////////////////////////////////////////////////////
  // bundles
  //////////////////////////////////////////////////////////////////////

  // one access from the execute stage, held until done
  typedef struct packed {
    logic        we;
    lsu_type_e   data_type;
    logic        sign_ext;
    logic [31:0] addr;
    logic [31:0] wdata;
  } lsu_req_t;

  // address phase payload towards memory
  typedef struct packed {
    logic [31:0] addr;
    logic        we;
    logic [3:0]  be;
    logic [31:0] wdata;
  } bus_req_t;

  // attributes kept for the response phase
  typedef struct packed {
    logic [1:0] offset;
    lsu_type_e  data_type;
    logic       sign_ext;
    logic       we;
  } lsu_ctrl_t;

endpackage

// File: design/lsu_store_align.sv
/*
  byte enables and write data placement for both parts of an access
  the rotated word serves both parts, only the enables differ
*/
module lsu_store_align import lsu_pkg::*; (
  input  lsu_type_e   req_type_i,
  input  logic [1:0]  req_offset_i,
  input  logic        second_part_i,
  input  logic [31:0] wdata_i,
  output logic [3:0]  be_o,
  output logic [31:0] wdata_o
);

  //////////////////////////////////////////////////////////////////////
  // byte enables
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (req_type_i)
      LSU_WORD: begin
        if (!second_part_i) begin
          // bytes from the offset up to the top of the word
          unique case (req_offset_i)
            2'b00:   be_o = 4'b1111;
            2'b01:   be_o = 4'b1110;
            2'b10:   be_o = 4'b1100;
            default: be_o = 4'b1000;
          endcase
        end else begin
          // spill-over bytes at the bottom of the next word
          unique case (req_offset_i)
            2'b00:   be_o = 4'b0000;
            2'b01:   be_o = 4'b0001;
            2'b10:   be_o = 4'b0011;
            default: be_o = 4'b0111;
          endcase
        end
      end

      LSU_HALF: begin
        if (!second_part_i) begin
          unique case (req_offset_i)
            2'b00:   be_o = 4'b0011;
            2'b01:   be_o = 4'b0110;
            2'b10:   be_o = 4'b1100;
            default: be_o = 4'b1000;
          endcase
        end else begin
          // only offset 3 reaches a second part
          be_o = 4'b0001;
        end
      end

      // byte, code 2'b11 lands here as well
      default: begin
        be_o = 4'b0001 << req_offset_i;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // write data rotation
  //////////////////////////////////////////////////////////////////////

  // rotate left by the byte offset, wrapped bytes feed the second part
  always_comb begin
    unique case (req_offset_i)
      2'b00:   wdata_o = wdata_i;
      2'b01:   wdata_o = {wdata_i[23:0], wdata_i[31:24]};
      2'b10:   wdata_o = {wdata_i[15:0], wdata_i[31:16]};
      default: wdata_o = {wdata_i[7:0], wdata_i[31:8]};
    endcase
  end

endmodule

// File: design/lsu_top.sv
/*
  load/store unit, one access in flight, split word accesses handled internally
  requester holds lsu_req_i and lsu_req_info_i stable until lsu_req_done_o
  addresses above AddrWidth are dropped on the bus side
*/
module lsu_top import lsu_pkg::*; #(
  parameter int unsigned AddrWidth = 32
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  // execute stage
  input  logic                 lsu_req_i,
  input  lsu_req_t             lsu_req_info_i,
  output logic                 lsu_req_done_o,
  output logic                 lsu_resp_valid_o,
  output logic                 lsu_rdata_valid_o,
  output logic [31:0]          lsu_rdata_o,
  output logic                 load_err_o,
  output logic                 store_err_o,
  output logic                 busy_o,
  output logic [AddrWidth-1:0] addr_last_o,

  // data bus
  output logic                 data_req_o,
  output bus_req_t             data_bus_o,
  input  logic                 data_gnt_i,
  input  logic                 data_rvalid_i,
  input  logic                 data_err_i,
  input  logic [31:0]          data_rdata_i
);

  logic                 second_part;
  logic                 ctrl_update;
  logic                 rdata_update;
  logic                 addr_update;
  logic [AddrWidth-1:0] bus_addr;
  logic [3:0]           bus_be;
  logic [31:0]          bus_wdata;
  lsu_ctrl_t            ctrl_d;
  lsu_ctrl_t            ctrl_q;

  // attributes of the current request, registered by the load aligner
  assign ctrl_d = '{
    offset:    lsu_req_info_i.addr[1:0],
    data_type: lsu_req_info_i.data_type,
    sign_ext:  lsu_req_info_i.sign_ext,
    we:        lsu_req_info_i.we
  };

  lsu_ctrl_fsm u_ctrl_fsm (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .lsu_req_i         (lsu_req_i),
    .req_type_i        (lsu_req_info_i.data_type),
    .req_offset_i      (lsu_req_info_i.addr[1:0]),
    .ctrl_q_i          (ctrl_q),
    .data_gnt_i        (data_gnt_i),
    .data_rvalid_i     (data_rvalid_i),
    .data_err_i        (data_err_i),
    .data_req_o        (data_req_o),
    .second_part_o     (second_part),
    .ctrl_update_o     (ctrl_update),
    .rdata_update_o    (rdata_update),
    .addr_update_o     (addr_update),
    .lsu_req_done_o    (lsu_req_done_o),
    .lsu_resp_valid_o  (lsu_resp_valid_o),
    .lsu_rdata_valid_o (lsu_rdata_valid_o),
    .load_err_o        (load_err_o),
    .store_err_o       (store_err_o),
    .busy_o            (busy_o)
  );

  lsu_addr_unit #(
    .AddrWidth (AddrWidth)
  ) u_addr_unit (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_addr_i    (lsu_req_info_i.addr[AddrWidth-1:0]),
    .second_part_i (second_part),
    .addr_update_i (addr_update),
    .bus_addr_o    (bus_addr),
    .addr_last_o   (addr_last_o)
  );

  lsu_store_align u_store_align (
    .req_type_i    (lsu_req_info_i.data_type),
    .req_offset_i  (lsu_req_info_i.addr[1:0]),
    .second_part_i (second_part),
    .wdata_i       (lsu_req_info_i.wdata),
    .be_o          (bus_be),
    .wdata_o       (bus_wdata)
  );

  lsu_load_align u_load_align (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .ctrl_update_i  (ctrl_update),
    .rdata_update_i (rdata_update),
    .ctrl_d_i       (ctrl_d),
    .data_rdata_i   (data_rdata_i),
    .ctrl_q_o       (ctrl_q),
    .lsu_rdata_o    (lsu_rdata_o)
  );

  // bus payload, upper address bits zero when AddrWidth < 32
  assign data_bus_o = '{
    addr:  32'(bus_addr),
    we:    lsu_req_info_i.we,
    be:    bus_be,
    wdata: bus_wdata
  };

endmodule

// File: sim/lsu_tests.txt
# op(0 load, 1 store) addr type(0 word, 1 half, 2 byte) sign wdata exp_rdata exp_err, all hex
# memory starts at zero, words with address bit 12 set answer with a bus error
1 00000100 0 0 87654321 00000000 0
0 00000100 0 0 00000000 87654321 0
1 00000104 1 0 000080f1 00000000 0
1 00000106 1 0 00007e22 00000000 0
0 00000104 1 1 00000000 ffff80f1 0
0 00000104 1 0 00000000 000080f1 0
1 00000109 2 0 000000a5 00000000 0
0 00000109 2 1 00000000 ffffffa5 0
0 00000109 2 0 00000000 000000a5 0
0 00000101 0 0 00000000 f1876543 0
0 00000102 0 0 00000000 80f18765 0
0 00000103 0 0 00000000 2280f187 0
0 00000103 1 1 00000000 fffff187 0
0 00000107 1 0 00000000 0000007e 0
1 00000200 0 0 11223344 00000000 0
1 00000204 0 0 55667788 00000000 0
1 00000201 0 0 a1b2c3d4 00000000 0
0 00000200 0 0 00000000 b2c3d444 0
0 00000204 0 0 00000000 556677a1 0
1 0000020b 1 0 0000e817 00000000 0
0 00000208 0 0 00000000 17000000 0
0 0000020c 0 0 00000000 000000e8 0
1 00000203 0 0 44332211 00000000 0
0 00000200 0 0 00000000 11c3d444 0
0 00000204 0 0 00000000 55443322 0
0 00001000 0 0 00000000 00000000 1
1 00001004 2 0 000000ff 00000000 1
0 00001ffd 0 0 00000000 00000000 1
1 00001ffe 0 0 12345678 00000000 1
0 00000ffe 0 0 00000000 00000000 1
1 00000fff 1 0 00001234 00000000 1
0 00000ffc 0 0 00000000 34000000 0

// File: sim/tb_lsu.sv
/*
  accesses and expected results come from sim/lsu_tests.txt
  memory grants after 0 to 3 cycles and answers in order
  words with address bit 12 set answer with a bus error
  run from the project root so that the test file path resolves
*/
module tb_lsu import lsu_pkg::*; ();

  localparam int unsigned DriveDelay = 5;
  localparam int unsigned WaitLimit  = 20;
  localparam logic [31:0] Seed       = 32'h807a1aeb;

  logic        clk_i;
  logic        rst_ni;
  logic        lsu_req;
  lsu_req_t    lsu_req_info;
  logic        lsu_req_done;
  logic        lsu_resp_valid;
  logic        lsu_rdata_valid;
  logic [31:0] lsu_rdata;
  logic        load_err;
  logic        store_err;
  logic        busy;
  logic [31:0] addr_last;
  logic        data_req;
  bus_req_t    data_bus;
  logic        data_gnt;
  logic        data_rvalid;
  logic        data_err;
  logic [31:0] data_rdata;

  // sparse memory of words indexed by word address
  logic [31:0] mem [logic [29:0]];
  logic        gnt_ready;
  int unsigned gnt_wait;
  int unsigned cycle;
  int unsigned last_due;
  // outstanding responses with the oldest first
  int unsigned rsp_due_q[$];
  logic [31:0] rsp_data_q[$];
  logic        rsp_err_q[$];

  int unsigned value_errs;
  int unsigned order_errs;
  int unsigned timeout_errs;
  int unsigned setup_errs;
  int unsigned resp_count;
  int unsigned done_count;

  lsu_top #(
    .AddrWidth (32)
  ) UUT (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .lsu_req_i         (lsu_req),
    .lsu_req_info_i    (lsu_req_info),
    .lsu_req_done_o    (lsu_req_done),
    .lsu_resp_valid_o  (lsu_resp_valid),
    .lsu_rdata_valid_o (lsu_rdata_valid),
    .lsu_rdata_o       (lsu_rdata),
    .load_err_o        (load_err),
    .store_err_o       (store_err),
    .busy_o            (busy),
    .addr_last_o       (addr_last),
    .data_req_o        (data_req),
    .data_bus_o        (data_bus),
    .data_gnt_i        (data_gnt),
    .data_rvalid_i     (data_rvalid),
    .data_err_i        (data_err),
    .data_rdata_i      (data_rdata)
  );

  always #50 clk_i = ~clk_i;

  //////////////////////////////////////////////////////////////////////
  // memory model
  //////////////////////////////////////////////////////////////////////

  // grant follows the request once the random wait has run out
  assign data_gnt = data_req & gnt_ready;

  always begin : memory_model
    logic [29:0] idx;
    logic [31:0] word;
    int unsigned due;
    @(posedge clk_i);
    #DriveDelay;
    cycle++;
    gnt_ready = (gnt_wait == 0);
    if (rsp_due_q.size() > 0 && rsp_due_q[0] == cycle) begin
      data_rvalid = 1'b1;
      data_rdata  = rsp_data_q[0];
      data_err    = rsp_err_q[0];
    end else begin
      data_rvalid = 1'b0;
      data_rdata  = '0;
      data_err    = 1'b0;
    end
    // outputs are settled mid cycle
    @(negedge clk_i);
    if (data_rvalid) begin
      void'(rsp_due_q.pop_front());
      void'(rsp_data_q.pop_front());
      void'(rsp_err_q.pop_front());
    end
    if (data_req && data_gnt) begin
      idx  = data_bus.addr[31:2];
      word = mem.exists(idx) ? mem[idx] : 32'h0;
      // errored words are never written
      if (data_bus.we && !data_bus.addr[12]) begin
        for (int b = 0; b < 4; b++) begin
          if (data_bus.be[b]) word[8*b +: 8] = data_bus.wdata[8*b +: 8];
        end
        mem[idx] = word;
      end
      // rvalid 1 to 3 cycles after the grant and kept in order
      due = cycle + 1 + ($urandom % 3);
      if (due <= last_due) due = last_due + 1;
      last_due = due;
      rsp_due_q.push_back(due);
      rsp_data_q.push_back(data_bus.we ? 32'h0 : word);
      rsp_err_q.push_back(data_bus.addr[12]);
      gnt_wait = $urandom % 4;
    end else if (data_req && gnt_wait > 0) begin
      gnt_wait--;
    end
  end

  // pulse counters for the once per access rule
  always @(negedge clk_i) begin
    if (lsu_resp_valid) resp_count++;
    if (lsu_req_done) done_count++;
  end

  //////////////////////////////////////////////////////////////////////
  // request driver and checks
  //////////////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
    value_errs++;
    $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
  endtask

  task automatic run_access(input int unsigned index, input logic we,
                            input logic [31:0] addr, input logic [1:0] dtype,
                            input logic sext, input logic [31:0] wdata,
                            input logic [31:0] exp_rdata, input logic exp_err,
                            output logic timed_out);
    int unsigned waited;
    int unsigned grants;
    int unsigned exp_grants;
    logic        split;
    logic [31:0] second_word;
    logic [31:0] exp_last;
    // split when a word leaves its boundary or a half word starts at offset 3
    split = ((dtype == 2'd0) && (addr[1:0] != 2'd0)) ||
            ((dtype == 2'd1) && (addr[1:0] == 2'd3));
    second_word = {addr[31:2] + 30'd1, 2'b00};
    // first part failing keeps the request address
    exp_last  = (split && !addr[12]) ? second_word : addr;
    // one bus access per word touched
    exp_grants = split ? 2 : 1;
    grants     = 0;
    timed_out = 1'b0;
    @(posedge clk_i);
    if (resp_count != index) begin
      order_errs++;
      $display("Error at %0t: %0d responses before access %0d", $time, resp_count, index);
    end
    #DriveDelay;
    lsu_req                = 1'b1;
    lsu_req_info.we        = we;
    lsu_req_info.data_type = lsu_type_e'(dtype);
    lsu_req_info.sign_ext  = sext;
    lsu_req_info.addr      = addr;
    lsu_req_info.wdata     = wdata;
    // hold the request until the last grant
    waited = 0;
    do begin
      @(negedge clk_i);
      waited++;
      if (data_gnt) grants++;
      if (lsu_resp_valid) begin
        order_errs++;
        $display("Error at %0t: response before done for address %h", $time, addr);
      end
    end while (!lsu_req_done && waited < WaitLimit);
    if (!lsu_req_done) begin
      timeout_errs++;
      timed_out = 1'b1;
      $display("Timeout at %0t: no lsu_req_done_o for address %h", $time, addr);
      return;
    end
    // done belongs to the cycle of the last grant
    if (!data_gnt) begin
      order_errs++;
      $display("Error at %0t: lsu_req_done_o without a bus grant for address %h", $time, addr);
    end
    @(posedge clk_i);
    #DriveDelay;
    lsu_req = 1'b0;
    waited  = 0;
    do begin
      @(negedge clk_i);
      waited++;
      if (data_gnt) grants++;
    end while (!lsu_resp_valid && waited < WaitLimit);
    if (!lsu_resp_valid) begin
      timeout_errs++;
      timed_out = 1'b1;
      $display("Timeout at %0t: no lsu_resp_valid_o for address %h", $time, addr);
      return;
    end
    if (busy) report_mismatch("busy_o", 32'(busy), 32'h0);
    if (grants != exp_grants) report_mismatch("bus grants", grants, exp_grants);
    if (we) begin
      if (store_err !== exp_err) report_mismatch("store_err_o", 32'(store_err), 32'(exp_err));
      if (load_err) report_mismatch("load_err_o", 32'(load_err), 32'h0);
      if (lsu_rdata_valid) report_mismatch("lsu_rdata_valid_o", 32'(lsu_rdata_valid), 32'h0);
    end else begin
      if (load_err !== exp_err) report_mismatch("load_err_o", 32'(load_err), 32'(exp_err));
      if (store_err) report_mismatch("store_err_o", 32'(store_err), 32'h0);
      if (lsu_rdata_valid !== !exp_err) begin
        report_mismatch("lsu_rdata_valid_o", 32'(lsu_rdata_valid), 32'(!exp_err));
      end
      if (!exp_err && lsu_rdata !== exp_rdata) report_mismatch("lsu_rdata_o", lsu_rdata, exp_rdata);
    end
    if (addr_last !== exp_last) report_mismatch("addr_last_o", addr_last, exp_last);
  endtask

  initial begin : main_sequence
    int          fd;
    int          fields;
    string       line;
    logic [31:0] f_op, f_addr, f_type, f_sign, f_wdata, f_rdata, f_err;
    int unsigned accesses;
    logic        timed_out;
    void'($urandom(Seed));
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    lsu_req      = 1'b0;
    lsu_req_info = '0;
    gnt_ready    = 1'b0;
    data_rvalid  = 1'b0;
    data_err     = 1'b0;
    data_rdata   = '0;
    gnt_wait     = $urandom % 4;
    accesses     = 0;
    timed_out    = 1'b0;
    repeat (16) @(posedge clk_i);
    #DriveDelay;
    rst_ni = 1'b1;

    fd = $fopen("sim/lsu_tests.txt", "r");
    if (fd == 0) begin
      setup_errs++;
      $display("Could not open sim/lsu_tests.txt for reading");
    end
    while (fd != 0 && !$feof(fd) && !timed_out) begin
      line = "";
      void'($fgets(line, fd));
      // skip blank and comment lines
      if (line.len() > 1 && line.getc(0) != "#") begin
        fields = $sscanf(line, "%h %h %h %h %h %h %h",
                         f_op, f_addr, f_type, f_sign, f_wdata, f_rdata, f_err);
        if (fields == 7) begin
          run_access(accesses, f_op[0], f_addr, f_type[1:0], f_sign[0], f_wdata,
                     f_rdata, f_err[0], timed_out);
          accesses++;
        end else begin
          setup_errs++;
          $display("Test line could not be parsed: %s", line);
        end
      end
    end
    if (fd != 0) $fclose(fd);
    if (accesses == 0) begin
      setup_errs++;
      $display("No accesses were read from the test file");
    end

    // a few idle cycles to catch stray responses
    repeat (4) @(posedge clk_i);
    if (resp_count != accesses) begin
      order_errs++;
      $display("Error at %0t: %0d responses for %0d accesses", $time, resp_count, accesses);
    end
    if (done_count != accesses) begin
      order_errs++;
      $display("Error at %0t: %0d done pulses for %0d accesses", $time, done_count, accesses);
    end
    $display("%0d accesses, errors: %0d value, %0d order, %0d timeout, %0d setup",
             accesses, value_errs, order_errs, timeout_errs, setup_errs);
    if (value_errs + order_errs + timeout_errs + setup_errs == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: vlog.f
design/lsu_pkg.sv
design/lsu_addr_unit.sv
design/lsu_store_align.sv
design/lsu_load_align.sv
design/lsu_ctrl_fsm.sv
design/lsu_top.sv
sim/tb_lsu.sv
